//--- Makefile
# Verilator build and run for the BCP core testbench

VERILATOR ?= verilator
TOP       ?= tb_sat_bcp
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  := Simulation FAILED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and scan $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "test finished without failure, log in $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/bcp_dispatch.sv
`default_nettype none

module bcp_dispatch #(
    parameter int NUM_ENGINE = 2
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   in_valid,
    output logic                        in_ready,
    input  wire sat_pkg::bcp_cmd_t      in_cmd,
    output logic                        wr_en,
    output sat_pkg::lit_t               wr_lit,
    output logic                        clr,
    output logic [NUM_ENGINE-1:0]       issue_valid,
    output sat_pkg::cla_t               issue_cla,
    input  wire logic [NUM_ENGINE-1:0]  busy
);

    localparam int PTR_W = (NUM_ENGINE > 1) ? $clog2(NUM_ENGINE) : 1;

    // engine next in rotation
    logic [PTR_W-1:0] ptr;
    logic             is_eval;
    logic             issue_ok;

    assign is_eval  = (in_cmd.op == sat_pkg::CMD_EVAL);

    // eval waits for its engine, everything else goes straight through
    assign in_ready = !is_eval || !busy[ptr];
    assign issue_ok = in_valid && is_eval && !busy[ptr];

    // table side
    assign wr_en  = in_valid && (in_cmd.op == sat_pkg::CMD_ASSIGN);
    assign wr_lit = in_cmd.lit;
    assign clr    = in_valid && (in_cmd.op == sat_pkg::CMD_CLEAR);

    // clause bus shared by all engines, issue_valid picks one
    assign issue_cla = in_cmd.cla;

    always_comb begin
        issue_valid = '0;
        if (issue_ok) begin
            issue_valid[ptr] = 1'b1;
        end
    end

    // unknown op codes are accepted and dropped

    // rotation advances per issued eval only
    always_ff @(posedge clk) begin
        if (rst_n) begin
            ptr <= '0;
        end else if (issue_ok) begin
            if (ptr == PTR_W'(NUM_ENGINE - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + PTR_W'(1);
            end
        end
    end

    // stalled eval stays offered unchanged until its engine frees
    assert property (@(posedge clk) disable iff (rst_n)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_cmd)));

endmodule

`default_nettype wire

//--- rtl/bcp_engine.sv
`default_nettype none

module bcp_engine (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   issue,
    input  wire sat_pkg::cla_t          cla,
    output sat_pkg::cla_t               look_cla,
    input  wire sat_pkg::state_vec_t    look_state,
    output logic                        busy,
    output logic                        done,
    input  wire logic                   take,
    output sat_pkg::bcp_result_t        result
);

    localparam int CNT_W = $clog2(sat_pkg::CLA_LEN + 1);

    // clause and its literal values frozen at issue
    sat_pkg::cla_t        cla_r;
    sat_pkg::state_vec_t  st_r;
    logic                 pend;
    sat_pkg::bcp_result_t verdict;

    // lookup runs on the issue bus so states are ready in the issue cycle
    assign look_cla = cla;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            pend <= 1'b0;
        end else begin
            if (issue) begin
                busy <= 1'b1;
                pend <= 1'b1;
            end
            // classify one cycle after capture
            if (pend) begin
                pend <= 1'b0;
                done <= 1'b1;
            end
            // collector frees the engine
            if (take) begin
                done <= 1'b0;
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            cla_r <= cla;
            st_r  <= look_state;
        end
        if (pend) begin
            result <= verdict;
        end
    end

    // sat, then conflict, then unit, else unresolved
    always_comb begin
        logic              any_true;
        logic [CNT_W-1:0]  n_undef;
        sat_pkg::lit_t     unit_lit;
        any_true = 1'b0;
        n_undef  = '0;
        unit_lit = '0;
        for (int i = 0; i < sat_pkg::CLA_LEN; i++) begin
            if (st_r[i] == sat_pkg::TRUE) begin
                any_true = 1'b1;
            end else if (st_r[i] == sat_pkg::UNDEFINED) begin
                n_undef  = n_undef + CNT_W'(1);
                unit_lit = cla_r[i];
            end
        end
        verdict.lit = '0;
        if (any_true) begin
            verdict.status = sat_pkg::SAT;
        end else if (n_undef == '0) begin
            verdict.status = sat_pkg::CONFLICT;
        end else if (n_undef == CNT_W'(1)) begin
            verdict.status = sat_pkg::UNIT;
            verdict.lit    = unit_lit;
        end else begin
            verdict.status = sat_pkg::UNRESOLVED;
        end
    end

    // dispatcher holds evals off a busy engine
    assert property (@(posedge clk) disable iff (rst_n) issue |-> !busy);

endmodule

`default_nettype wire

//--- rtl/cmd_rx.sv
`default_nettype none

module cmd_rx (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               cmd_req,
    input  wire sat_pkg::bcp_cmd_t  cmd,
    output logic                    cmd_ack,
    output logic                    in_valid,
    input  wire logic               in_ready,
    output sat_pkg::bcp_cmd_t       in_cmd
);

    // two-flop synchronizer on the host request
    logic req_meta;
    logic req_sync;
    logic capture;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            req_meta <= 1'b0;
            req_sync <= 1'b0;
        end else begin
            req_meta <= cmd_req;
            req_sync <= req_meta;
        end
    end

    // new request seen, no ack outstanding, holding register free
    assign capture = req_sync && !cmd_ack && !in_valid;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            cmd_ack  <= 1'b0;
            in_valid <= 1'b0;
        end else if (capture) begin
            cmd_ack  <= 1'b1;
            in_valid <= 1'b1;
        end else begin
            // ack follows the request down
            if (!req_sync) begin
                cmd_ack <= 1'b0;
            end
            // holding register empties on the transfer
            if (in_valid && in_ready) begin
                in_valid <= 1'b0;
            end
        end
    end

    // command is stable by now, req was held through the synchronizer
    always_ff @(posedge clk) begin
        if (capture) begin
            in_cmd <= cmd;
        end
    end

    // host keeps the command steady through the acknowledged phase
    assert property (@(posedge clk) disable iff (rst_n)
        (cmd_req && cmd_ack) |=> (!(cmd_req && cmd_ack) || $stable(cmd)));

endmodule

`default_nettype wire

//--- rtl/gst.sv
`default_nettype none

module gst #(
    parameter int NUM_ENGINE = 2
) (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic                                   wr_en,
    input  wire sat_pkg::lit_t                          wr_lit,
    input  wire logic                                   clr,
    input  wire sat_pkg::cla_t [NUM_ENGINE-1:0]         look_cla,
    output sat_pkg::state_vec_t [NUM_ENGINE-1:0]        look_state
);

    // one state per variable, entry 0 never written
    sat_pkg::lit_state_t           tbl [sat_pkg::VAR_MAX];
    logic [sat_pkg::VAR_W-1:0]     wr_var;

    assign wr_var = sat_pkg::lit_var(wr_lit);

    // clear wins over a write in the same cycle
    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int v = 0; v < sat_pkg::VAR_MAX; v++) begin
                tbl[v] <= sat_pkg::UNDEFINED;
            end
        end else if (clr) begin
            for (int v = 0; v < sat_pkg::VAR_MAX; v++) begin
                tbl[v] <= sat_pkg::UNDEFINED;
            end
        end else if (wr_en) begin
            // positive literal makes its variable true
            if (wr_lit[sat_pkg::LIT_W-1]) begin
                tbl[wr_var] <= sat_pkg::FALSE;
            end else begin
                tbl[wr_var] <= sat_pkg::TRUE;
            end
        end
    end

    // combinational lookup, one port per engine
    always_comb begin
        sat_pkg::lit_t       lit;
        sat_pkg::lit_state_t st;
        for (int e = 0; e < NUM_ENGINE; e++) begin
            for (int i = 0; i < sat_pkg::CLA_LEN; i++) begin
                lit = look_cla[e][i];
                st  = tbl[sat_pkg::lit_var(lit)];
                if (lit == '0) begin
                    // empty slot
                    look_state[e][i] = sat_pkg::FALSE;
                end else if (st == sat_pkg::UNDEFINED || !lit[sat_pkg::LIT_W-1]) begin
                    look_state[e][i] = st;
                end else if (st == sat_pkg::TRUE) begin
                    // negated literal swaps the value
                    look_state[e][i] = sat_pkg::FALSE;
                end else begin
                    look_state[e][i] = sat_pkg::TRUE;
                end
            end
        end
    end

    // host never assigns the empty literal
    assert property (@(posedge clk) disable iff (rst_n)
        (wr_en && !clr) |-> (wr_var != '0));

endmodule

`default_nettype wire

//--- rtl/result_tx.sv
`default_nettype none

module result_tx #(
    parameter int NUM_ENGINE = 2
) (
    input  wire logic                                       clk,
    input  wire logic                                       rst_n,
    input  wire logic [NUM_ENGINE-1:0]                      done,
    input  wire sat_pkg::bcp_result_t [NUM_ENGINE-1:0]      result,
    output logic [NUM_ENGINE-1:0]                           take,
    output logic                                            res_req,
    output sat_pkg::bcp_result_t                            res,
    input  wire logic                                       res_ack
);

    localparam int PTR_W = (NUM_ENGINE > 1) ? $clog2(NUM_ENGINE) : 1;

    typedef enum logic [1:0] {
        TX_IDLE = 2'd0,
        TX_REQ  = 2'd1,
        TX_DROP = 2'd2
    } tx_state_t;

    tx_state_t        state;
    // engine whose result goes out next, same rotation as dispatch
    logic [PTR_W-1:0] ptr;
    logic             ack_meta;
    logic             ack_sync;
    logic             grab;

    // host ack through two flops
    always_ff @(posedge clk) begin
        if (rst_n) begin
            ack_meta <= 1'b0;
            ack_sync <= 1'b0;
        end else begin
            ack_meta <= res_ack;
            ack_sync <= ack_meta;
        end
    end

    // only the pointed engine is ever collected
    assign grab = (state == TX_IDLE) && done[ptr];

    always_comb begin
        take = '0;
        if (grab) begin
            take[ptr] = 1'b1;
        end
    end

    // four-phase request side
    always_ff @(posedge clk) begin
        if (rst_n) begin
            state   <= TX_IDLE;
            res_req <= 1'b0;
            ptr     <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (grab) begin
                        res_req <= 1'b1;
                        state   <= TX_REQ;
                    end
                end
                TX_REQ: begin
                    if (ack_sync) begin
                        res_req <= 1'b0;
                        state   <= TX_DROP;
                    end
                end
                TX_DROP: begin
                    // handshake over once ack is back low
                    if (!ack_sync) begin
                        state <= TX_IDLE;
                        if (ptr == PTR_W'(NUM_ENGINE - 1)) begin
                            ptr <= '0;
                        end else begin
                            ptr <= ptr + PTR_W'(1);
                        end
                    end
                end
                default: begin
                    state   <= TX_IDLE;
                    res_req <= 1'b0;
                end
            endcase
        end
    end

    // result held stable for the whole handshake
    always_ff @(posedge clk) begin
        if (grab) begin
            res <= result[ptr];
        end
    end

endmodule

`default_nettype wire

//--- rtl/sat_bcp_top.sv
`default_nettype none

module sat_bcp_top #(
    parameter int NUM_ENGINE = 2
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               cmd_req,
    input  wire sat_pkg::bcp_cmd_t  cmd,
    output logic                    cmd_ack,
    output logic                    res_req,
    output sat_pkg::bcp_result_t    res,
    input  wire logic               res_ack
);

    // receiver to dispatcher
    logic                                   in_valid;
    logic                                   in_ready;
    sat_pkg::bcp_cmd_t                      in_cmd;

    // dispatcher to table
    logic                                   wr_en;
    sat_pkg::lit_t                          wr_lit;
    logic                                   clr;

    // dispatcher, table and engines
    logic [NUM_ENGINE-1:0]                  issue_valid;
    sat_pkg::cla_t                          issue_cla;
    logic [NUM_ENGINE-1:0]                  busy;
    sat_pkg::cla_t [NUM_ENGINE-1:0]         look_cla;
    sat_pkg::state_vec_t [NUM_ENGINE-1:0]   look_state;

    // engines to sender
    logic [NUM_ENGINE-1:0]                  done;
    logic [NUM_ENGINE-1:0]                  take;
    sat_pkg::bcp_result_t [NUM_ENGINE-1:0]  result;

    cmd_rx u_cmd_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_req  (cmd_req),
        .cmd      (cmd),
        .cmd_ack  (cmd_ack),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_cmd   (in_cmd)
    );

    bcp_dispatch #(.NUM_ENGINE(NUM_ENGINE)) u_dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_cmd      (in_cmd),
        .wr_en       (wr_en),
        .wr_lit      (wr_lit),
        .clr         (clr),
        .issue_valid (issue_valid),
        .issue_cla   (issue_cla),
        .busy        (busy)
    );

    gst #(.NUM_ENGINE(NUM_ENGINE)) u_gst (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_lit     (wr_lit),
        .clr        (clr),
        .look_cla   (look_cla),
        .look_state (look_state)
    );

    // one engine per rotation slot
    for (genvar k = 0; k < NUM_ENGINE; k++) begin : g_engine
        bcp_engine u_engine (
            .clk        (clk),
            .rst_n      (rst_n),
            .issue      (issue_valid[k]),
            .cla        (issue_cla),
            .look_cla   (look_cla[k]),
            .look_state (look_state[k]),
            .busy       (busy[k]),
            .done       (done[k]),
            .take       (take[k]),
            .result     (result[k])
        );
    end

    result_tx #(.NUM_ENGINE(NUM_ENGINE)) u_result_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .done    (done),
        .result  (result),
        .take    (take),
        .res_req (res_req),
        .res     (res),
        .res_ack (res_ack)
    );

endmodule

`default_nettype wire

//--- rtl/sat_pkg.sv
`default_nettype none

package sat_pkg;

    // literal layout, low bits index the variable
    localparam int LIT_W   = 8;
    localparam int VAR_W   = LIT_W - 1;
    localparam int VAR_MAX = 128;
    localparam int CLA_LEN = 4;

    // two's complement literal, negative is the negated variable, zero is an empty slot
    typedef logic signed [LIT_W-1:0] lit_t;

    typedef lit_t [CLA_LEN-1:0] cla_t;

    typedef enum logic [1:0] {
        UNDEFINED = 2'd0,
        TRUE      = 2'd1,
        FALSE     = 2'd2
    } lit_state_t;

    // per-slot values for one clause lookup
    typedef lit_state_t [CLA_LEN-1:0] state_vec_t;

    typedef enum logic [1:0] {
        CMD_ASSIGN = 2'd0,
        CMD_CLEAR  = 2'd1,
        CMD_EVAL   = 2'd2
    } cmd_op_t;

    // lit used by assign, cla used by eval
    typedef struct packed {
        cmd_op_t op;
        lit_t    lit;
        cla_t    cla;
    } bcp_cmd_t;

    typedef enum logic [1:0] {
        SAT        = 2'd0,
        CONFLICT   = 2'd1,
        UNIT       = 2'd2,
        UNRESOLVED = 2'd3
    } cla_status_t;

    // lit is the implied literal, zero unless UNIT
    typedef struct packed {
        cla_status_t status;
        lit_t        lit;
    } bcp_result_t;

    // variable index is the magnitude of the literal
    function automatic logic [VAR_W-1:0] lit_var(lit_t lit);
        lit_t mag;
        mag = lit[LIT_W-1] ? -lit : lit;
        return mag[VAR_W-1:0];
    endfunction

endpackage

`default_nettype wire

//--- tests/bcp_stim.txt
# op lit slot0 slot1 slot2 slot3 status implied, all hex
# op 0 assign 1 clear 2 eval; status 0 sat 1 conflict 2 unit 3 unresolved
2 00 01 02 00 00 3 00
2 00 00 00 00 00 1 00
2 00 05 00 00 00 2 05
0 01 00 00 00 00 0 00
2 00 01 02 00 00 0 00
2 00 ff 02 00 00 2 02
2 00 ff fe 00 00 2 fe
0 fe 00 00 00 00 0 00
2 00 ff 02 00 00 1 00
2 00 ff fe 00 00 0 00
2 00 ff 02 03 04 3 00
2 00 ff 02 03 00 2 03
0 03 00 00 00 00 0 00
2 00 fd ff 02 04 2 04
2 00 01 00 00 00 0 00
0 ff 00 00 00 00 0 00
2 00 01 00 00 00 1 00
2 00 ff 00 00 00 0 00
1 00 00 00 00 00 0 00
2 00 ff fe 00 00 3 00
2 00 03 00 00 00 2 03
0 0a 00 00 00 00 0 00
0 f7 00 00 00 00 0 00
2 00 0a 00 00 00 0 00
2 00 09 00 00 00 1 00
2 00 f7 0a 00 00 0 00
2 00 09 08 00 00 2 08
2 00 08 07 00 00 3 00
2 00 f6 09 00 00 1 00
2 00 f6 09 05 00 2 05

//--- tests/tb_sat_bcp.sv
`default_nettype none

module tb_sat_bcp;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    NUM_ENGINE   = 2;
    localparam int    CYC_PER_LINE = 40;
    localparam int    DRAIN_CYC    = 200;
    localparam string STIM_FILE    = "tests/bcp_stim.txt";

    logic                 clk;
    logic                 rst_n;
    logic                 cmd_req;
    sat_pkg::bcp_cmd_t    cmd;
    logic                 cmd_ack;
    logic                 res_req;
    sat_pkg::bcp_result_t res;
    logic                 res_ack;

    // stim lines in file order, expected values only matter for evals
    sat_pkg::bcp_cmd_t    stim_cmd [$];
    sat_pkg::bcp_result_t stim_exp [$];
    // evals sent and not yet answered
    sat_pkg::bcp_result_t exp_q [$];

    int err_count   = 0;
    int check_count = 0;
    int cycles      = 0;
    int cycle_limit = 0;
    bit reset_done  = 1'b0;

    sat_bcp_top #(.NUM_ENGINE(NUM_ENGINE)) dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd_req (cmd_req),
        .cmd     (cmd),
        .cmd_ack (cmd_ack),
        .res_req (res_req),
        .res     (res),
        .res_ack (res_ack)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // run guard, limit scales with the stim length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("run stopped after %0d cycles, a handshake never completed", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    // one line per command, hex fields, '#' lines skipped
    task automatic load_stim();
        int                   fd;
        int                   n;
        string                line;
        logic [31:0]          v [8];
        sat_pkg::bcp_cmd_t    c;
        sat_pkg::bcp_result_t e;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            err_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
                if (n != 8) begin
                    $display("stimulus line has the wrong number of fields: %s", line);
                    err_count++;
                end else begin
                    c.op  = sat_pkg::cmd_op_t'(v[0][1:0]);
                    c.lit = sat_pkg::lit_t'(v[1][7:0]);
                    // slot i of the clause from column 2+i
                    for (int i = 0; i < sat_pkg::CLA_LEN; i++) begin
                        c.cla[i] = sat_pkg::lit_t'(v[2+i][7:0]);
                    end
                    e.status = sat_pkg::cla_status_t'(v[6][1:0]);
                    e.lit    = sat_pkg::lit_t'(v[7][7:0]);
                    stim_cmd.push_back(c);
                    stim_exp.push_back(e);
                end
            end
        end
        $fclose(fd);
    endtask

    // four-phase sender, next req only once ack is back low
    task automatic send_cmd(input sat_pkg::bcp_cmd_t c);
        @(posedge clk);
        cmd     <= c;
        cmd_req <= 1'b1;
        @(posedge clk);
        while (!cmd_ack) @(posedge clk);
        cmd_req <= 1'b0;
        @(posedge clk);
        while (cmd_ack) @(posedge clk);
    endtask

    // host side of the result channel, random ack delay
    initial begin : result_side
        sat_pkg::bcp_result_t e;
        int                   delay;
        res_ack = 1'b0;
        void'($urandom(32'h7062d88a));
        wait (reset_done);
        forever begin
            @(posedge clk);
            if (res_req && !res_ack) begin
                if (exp_q.size() == 0) begin
                    $display("a result 0x%0h arrived with no eval outstanding", res);
                    err_count++;
                end else begin
                    e = exp_q.pop_front();
                    check_val("res.status", 32'(res.status), 32'(e.status));
                    check_val("res.lit", 32'(res.lit), 32'(e.lit));
                end
                delay = int'($urandom % 6);
                repeat (delay) @(posedge clk);
                res_ack <= 1'b1;
                @(posedge clk);
                while (res_req) @(posedge clk);
                res_ack <= 1'b0;
            end
        end
    end

    initial begin : command_side
        int wait_cnt;
        rst_n   = 1'b1;
        cmd_req = 1'b0;
        cmd     = '0;
        load_stim();
        if (stim_cmd.size() == 0) begin
            $display("no usable lines in the stimulus file");
            err_count++;
        end
        cycle_limit = CYC_PER_LINE * (stim_cmd.size() + 1);
        // reset is active high here
        repeat (2) @(posedge clk);
        rst_n      <= 1'b0;
        reset_done = 1'b1;
        for (int i = 0; i < stim_cmd.size(); i++) begin
            // expectation queued before the eval can possibly answer
            if (stim_cmd[i].op == sat_pkg::CMD_EVAL) begin
                exp_q.push_back(stim_exp[i]);
            end
            send_cmd(stim_cmd[i]);
        end
        // let outstanding results come back
        wait_cnt = 0;
        while ((exp_q.size() != 0 || res_req || res_ack) && wait_cnt < DRAIN_CYC) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d eval results never came back", exp_q.size());
            err_count++;
        end
        // quiet window, a repeated result would show up here
        repeat (20) @(posedge clk);
        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
rtl/sat_pkg.sv
rtl/cmd_rx.sv
rtl/bcp_dispatch.sv
rtl/gst.sv
rtl/bcp_engine.sv
rtl/result_tx.sv
rtl/sat_bcp_top.sv
tests/tb_sat_bcp.sv
